// File: src/pool_pkg.sv
`default_nettype none

package pool_pkg;

	localparam int DATA_W    = 8;
	localparam int ADDR_W    = 10;
	localparam int MEM_DEPTH = 1024;
	localparam int NUM_REQ   = 3;
	localparam int MAX_ROW   = 32;

	// arbiter priority, lowest index wins
	localparam int REQ_HOST = 0;
	localparam int REQ_RELU = 1;
	localparam int REQ_POOL = 2;

	typedef logic signed [DATA_W-1:0] pixel_t;
	typedef logic [ADDR_W-1:0] addr_t;

	typedef struct packed {
		logic   valid;
		logic   we;
		addr_t  addr;
		pixel_t wdata;
	} mem_req_t;

	// num_row needs one bit more than the row index
	typedef struct packed {
		logic [$clog2(MAX_ROW):0] num_row;
		logic [2:0]               num_channel;
		addr_t                    in_base;
		addr_t                    out_base;
	} layer_cfg_t;

	typedef enum logic [1:0] {SEQ_IDLE, SEQ_RELU, SEQ_POOL} seq_state_t;
	typedef enum logic [1:0] {POOL_IDLE, POOL_READ, POOL_WRITE} pool_state_t;
	typedef enum logic [1:0] {RELU_IDLE, RELU_READ, RELU_WRITE} relu_state_t;

endpackage

`default_nettype wire

// File: src/feature_ram.sv
`timescale 1ns/1ns
`default_nettype none

module feature_ram import pool_pkg::*; (
	input  wire logic     clk,
	input  wire mem_req_t req,
	output pixel_t        rdata
);

	pixel_t mem [MEM_DEPTH];

	// single port, write or read per cycle
	always_ff @(posedge clk) begin
		if (req.valid) begin
			if (req.we) begin
				mem[req.addr] <= req.wdata;
			end else begin
				// read data holds until the next read
				rdata <= mem[req.addr];
			end
		end
	end

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter import pool_pkg::*; (
	input  wire mem_req_t     reqs [NUM_REQ],
	output logic [NUM_REQ-1:0] gnts,
	output mem_req_t          mem_req
);

	// walk from lowest priority up so the lowest valid index wins
	always_comb begin
		gnts    = '0;
		mem_req = '0;
		for (int i = NUM_REQ - 1; i >= 0; i--) begin
			if (reqs[i].valid) begin
				gnts    = '0;
				gnts[i] = 1'b1;
				mem_req = reqs[i];
			end
		end
	end

endmodule

`default_nettype wire

// File: src/relu_unit.sv
`timescale 1ns/1ns
`default_nettype none

module relu_unit import pool_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       start,
	input  wire layer_cfg_t cfg,
	output mem_req_t        req,
	input  wire logic       gnt,
	input  wire pixel_t     rdata,
	output logic            done
);

	relu_state_t state;
	layer_cfg_t  cfg_q;
	logic [14:0] cnt;
	logic [14:0] num_pix;
	logic        rd_pend;
	pixel_t      wdata_q;

	assign num_pix = cfg_q.num_row * cfg_q.num_row * cfg_q.num_channel;

	always_ff @(posedge clk) begin
		if (start) begin
			cfg_q <= cfg;
		end
	end

	// rdata is valid in the cycle after the read grant
	always_ff @(posedge clk) begin
		if (state == RELU_WRITE && rd_pend) begin
			wdata_q <= rdata[DATA_W-1] ? '0 : rdata;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state   <= RELU_IDLE;
			cnt     <= '0;
			rd_pend <= 1'b0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				RELU_IDLE: begin
					if (start) begin
						cnt   <= '0;
						state <= RELU_READ;
					end
				end
				RELU_READ: begin
					if (gnt) begin
						rd_pend <= 1'b1;
						state   <= RELU_WRITE;
					end
				end
				RELU_WRITE: begin
					if (rd_pend) begin
						rd_pend <= 1'b0;
					end else if (gnt) begin
						if (cnt == num_pix - 15'd1) begin
							state <= RELU_IDLE;
							done  <= 1'b1;
						end else begin
							cnt   <= cnt + 15'd1;
							state <= RELU_READ;
						end
					end
				end
				default: state <= RELU_IDLE;
			endcase
		end
	end

	// write request waits out the data cycle
	always_comb begin
		req.valid = (state == RELU_READ) || (state == RELU_WRITE && !rd_pend);
		req.we    = (state == RELU_WRITE);
		req.addr  = cfg_q.in_base + cnt[ADDR_W-1:0];
		req.wdata = wdata_q;
	end

endmodule

`default_nettype wire

// File: src/pool_unit.sv
`timescale 1ns/1ns
`default_nettype none

module pool_unit import pool_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       start,
	input  wire layer_cfg_t cfg,
	output mem_req_t        req,
	input  wire logic       gnt,
	input  wire pixel_t     rdata,
	output logic            done
);

	pool_state_t                state;
	layer_cfg_t                 cfg_q;
	logic [2:0]                 ch;
	logic [$clog2(MAX_ROW)-1:0] orow;
	logic [$clog2(MAX_ROW)-1:0] ocol;
	logic [$clog2(MAX_ROW)-1:0] last_idx;
	logic [1:0]                 rd_idx;
	logic                       rd_pend;
	addr_t                      tl_addr;
	addr_t                      out_addr;
	addr_t                      rd_off;
	pixel_t                     max_q;
	logic                       last_win;

	// output map is num_row/2 square
	assign last_idx = cfg_q.num_row[$clog2(MAX_ROW):1] - 1'b1;
	assign last_win = (ocol == last_idx) && (orow == last_idx) &&
		(ch == cfg_q.num_channel - 3'd1);

	// window order: top-left, top-right, bottom-left, bottom-right
	assign rd_off = (rd_idx[1] ? addr_t'(cfg_q.num_row) : addr_t'(0)) + addr_t'(rd_idx[0]);

	always_ff @(posedge clk) begin
		if (start) begin
			cfg_q <= cfg;
		end
	end

	// running signed maximum, reset at each new window
	always_ff @(posedge clk) begin
		if ((state == POOL_IDLE && start) || (state == POOL_WRITE && !rd_pend && gnt)) begin
			max_q <= {1'b1, {(DATA_W-1){1'b0}}};
		end else if (rd_pend && rdata > max_q) begin
			max_q <= rdata;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state    <= POOL_IDLE;
			ch       <= '0;
			orow     <= '0;
			ocol     <= '0;
			rd_idx   <= '0;
			rd_pend  <= 1'b0;
			tl_addr  <= '0;
			out_addr <= '0;
			done     <= 1'b0;
		end else begin
			done    <= 1'b0;
			// one read in flight, data compared the cycle after its grant
			rd_pend <= (state == POOL_READ) && gnt;
			case (state)
				POOL_IDLE: begin
					if (start) begin
						ch       <= '0;
						orow     <= '0;
						ocol     <= '0;
						rd_idx   <= '0;
						tl_addr  <= cfg.in_base;
						out_addr <= cfg.out_base;
						state    <= POOL_READ;
					end
				end
				POOL_READ: begin
					if (gnt) begin
						rd_idx <= rd_idx + 2'd1;
						if (rd_idx == 2'd3) begin
							state <= POOL_WRITE;
						end
					end
				end
				POOL_WRITE: begin
					if (!rd_pend && gnt) begin
						out_addr <= out_addr + addr_t'(1);
						if (ocol == last_idx) begin
							// row end and channel end both skip one input row
							ocol    <= '0;
							tl_addr <= tl_addr + addr_t'(cfg_q.num_row) + addr_t'(2);
							if (orow == last_idx) begin
								orow <= '0;
								ch   <= ch + 3'd1;
							end else begin
								orow <= orow + 1'b1;
							end
						end else begin
							ocol    <= ocol + 1'b1;
							tl_addr <= tl_addr + addr_t'(2);
						end
						if (last_win) begin
							state <= POOL_IDLE;
							done  <= 1'b1;
						end else begin
							state <= POOL_READ;
						end
					end
				end
				default: state <= POOL_IDLE;
			endcase
		end
	end

	// wdata stays fixed while a read waits for its grant
	always_comb begin
		req.valid = (state == POOL_READ) || (state == POOL_WRITE && !rd_pend);
		req.we    = (state == POOL_WRITE);
		req.addr  = (state == POOL_WRITE) ? out_addr : tl_addr + rd_off;
		req.wdata = (state == POOL_WRITE) ? max_q : pixel_t'(0);
	end

endmodule

`default_nettype wire

// File: src/layer_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module layer_sequencer import pool_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       start,
	input  wire layer_cfg_t cfg,
	output logic            relu_start,
	output logic            pool_start,
	output layer_cfg_t      cfg_q,
	input  wire logic       relu_done,
	input  wire logic       pool_done,
	output logic            busy,
	output logic            done
);

	seq_state_t state;

	// busy covers the done cycle as well
	assign busy = (state != SEQ_IDLE) || done;

	always_ff @(posedge clk) begin
		if (state == SEQ_IDLE && start && !done) begin
			cfg_q <= cfg;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state      <= SEQ_IDLE;
			relu_start <= 1'b0;
			pool_start <= 1'b0;
			done       <= 1'b0;
		end else begin
			relu_start <= 1'b0;
			pool_start <= 1'b0;
			done       <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					if (start && !done) begin
						relu_start <= 1'b1;
						state      <= SEQ_RELU;
					end
				end
				SEQ_RELU: begin
					if (relu_done) begin
						pool_start <= 1'b1;
						state      <= SEQ_POOL;
					end
				end
				SEQ_POOL: begin
					if (pool_done) begin
						done  <= 1'b1;
						state <= SEQ_IDLE;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/pool_accel_top.sv
`timescale 1ns/1ns
`default_nettype none

module pool_accel_top import pool_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       start,
	input  wire layer_cfg_t cfg,
	output logic            busy,
	output logic            done,
	input  wire mem_req_t   host_req,
	output logic            host_gnt,
	output pixel_t          rdata
);

	mem_req_t             reqs [NUM_REQ];
	logic [NUM_REQ-1:0]   gnts;
	mem_req_t             mem_req;
	layer_cfg_t           cfg_q;
	logic                 relu_start;
	logic                 pool_start;
	logic                 relu_done;
	logic                 pool_done;

	assign reqs[REQ_HOST] = host_req;
	assign host_gnt       = gnts[REQ_HOST];

	layer_sequencer layer_sequencer_i (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.cfg        (cfg),
		.relu_start (relu_start),
		.pool_start (pool_start),
		.cfg_q      (cfg_q),
		.relu_done  (relu_done),
		.pool_done  (pool_done),
		.busy       (busy),
		.done       (done)
	);

	relu_unit relu_unit_i (
		.clk   (clk),
		.rst   (rst),
		.start (relu_start),
		.cfg   (cfg_q),
		.req   (reqs[REQ_RELU]),
		.gnt   (gnts[REQ_RELU]),
		.rdata (rdata),
		.done  (relu_done)
	);

	pool_unit pool_unit_i (
		.clk   (clk),
		.rst   (rst),
		.start (pool_start),
		.cfg   (cfg_q),
		.req   (reqs[REQ_POOL]),
		.gnt   (gnts[REQ_POOL]),
		.rdata (rdata),
		.done  (pool_done)
	);

	mem_arbiter mem_arbiter_i (
		.reqs    (reqs),
		.gnts    (gnts),
		.mem_req (mem_req)
	);

	feature_ram feature_ram_i (
		.clk   (clk),
		.req   (mem_req),
		.rdata (rdata)
	);

endmodule

`default_nettype wire

// File: tb/pool_accel_properties.sv
`timescale 1ns/1ns
`default_nettype none

module pool_accel_properties import pool_pkg::*; (
	input wire logic               clk,
	input wire logic               rst,
	input wire logic [NUM_REQ-1:0] gnts,
	input wire mem_req_t           host_req,
	input wire mem_req_t           relu_req,
	input wire mem_req_t           pool_req,
	input wire logic               done
);

	logic [NUM_REQ-1:0] valids;

	// bit positions follow the REQ_* priority indices
	assign valids = {pool_req.valid, relu_req.valid, host_req.valid};

	gnt_onehot: assert property (@(posedge clk) disable iff (!rst) $onehot0(gnts))
		else $error("more than one grant at once: %b", gnts);

	gnt_to_valid: assert property (@(posedge clk) disable iff (!rst) (gnts & ~valids) == '0)
		else $error("grant %b given without a valid request %b", gnts, valids);

	done_single: assert property (@(posedge clk) disable iff (!rst) done |=> !done)
		else $error("done high for two cycles");

	// a waiting request must not change until its grant
	host_hold: assert property (@(posedge clk) disable iff (!rst)
		host_req.valid && !gnts[REQ_HOST] |=> $stable(host_req))
		else $error("host request changed before grant");

	relu_hold: assert property (@(posedge clk) disable iff (!rst)
		relu_req.valid && !gnts[REQ_RELU] |=> $stable(relu_req))
		else $error("relu request changed before grant");

	pool_hold: assert property (@(posedge clk) disable iff (!rst)
		pool_req.valid && !gnts[REQ_POOL] |=> $stable(pool_req))
		else $error("pool request changed before grant");

endmodule

`default_nettype wire

// File: tb/pool_accel_tb.sv
`timescale 1ns/1ns
`default_nettype none

module pool_accel_tb import pool_pkg::*; ();

	localparam int NUM_TESTS    = 4;
	localparam int HOST_TIMEOUT = 100;
	localparam int RUN_TIMEOUT  = 20000;

	typedef enum logic [1:0] {FILL_RANDOM, FILL_NEG, FILL_RAMP} fill_t;

	typedef struct packed {
		layer_cfg_t cfg;
		fill_t      fill;
		logic       run;
	} test_row_t;

	logic       clk;
	logic       rst;
	logic       start;
	layer_cfg_t cfg;
	logic       busy;
	logic       done;
	mem_req_t   host_req;
	logic       host_gnt;
	pixel_t     rdata;

	test_row_t rows [NUM_TESTS];
	string     names [NUM_TESTS];
	pixel_t    img [4*MAX_ROW*MAX_ROW];
	int        seed = 32'h3d5706bc;
	int        num_checks;
	int        num_errors;
	int        tests_run;
	logic      timed_out;

	pool_accel_top pool_accel_top_i (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.cfg      (cfg),
		.busy     (busy),
		.done     (done),
		.host_req (host_req),
		.host_gnt (host_gnt),
		.rdata    (rdata)
	);

	bind pool_accel_top pool_accel_properties pool_accel_properties_i (
		.clk      (clk),
		.rst      (rst),
		.gnts     (gnts),
		.host_req (reqs[REQ_HOST]),
		.relu_req (reqs[REQ_RELU]),
		.pool_req (reqs[REQ_POOL]),
		.done     (done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic pixel_t relu(input pixel_t v);
		return (v < 0) ? pixel_t'(0) : v;
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		num_checks++;
		if (expected != actual) begin
			num_errors++;
			$display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	// entered and left 5 ns after a rising edge
	task automatic host_access(input string name, input logic we, input addr_t addr,
			input pixel_t wdata, output pixel_t data);
		int t;
		host_req.valid = 1'b1;
		host_req.we    = we;
		host_req.addr  = addr;
		host_req.wdata = wdata;
		t = 0;
		@(negedge clk);
		while (!host_gnt && t < HOST_TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (!host_gnt) begin
			$display("timeout: host port was never granted in test %s", name);
			num_errors++;
			timed_out = 1'b1;
		end
		@(posedge clk);
		#5;
		host_req = '0;
		@(negedge clk);
		data = rdata;
		@(posedge clk);
		#5;
	endtask

	task automatic run_layer(input string name, input layer_cfg_t c);
		int t;
		int busy_low;
		int host_lost;
		int extra_done;
		cfg   = c;
		start = 1'b1;
		@(posedge clk);
		#5;
		start = 1'b0;
		@(negedge clk);
		check_value({name, " busy after start"}, 1, int'(busy));
		@(posedge clk);
		#5;
		// start again while busy, must be ignored
		start = 1'b1;
		@(posedge clk);
		#5;
		start = 1'b0;
		// host reads compete with the units while the layer runs
		host_req.we    = 1'b0;
		host_req.addr  = c.in_base;
		host_req.wdata = '0;
		t         = 0;
		busy_low  = 0;
		host_lost = 0;
		@(negedge clk);
		while (!done && t < RUN_TIMEOUT) begin
			if (!busy) begin
				busy_low++;
			end
			if (host_req.valid && !host_gnt) begin
				host_lost++;
			end
			@(posedge clk);
			#5;
			host_req.valid = (t % 16) < 3;
			@(negedge clk);
			t++;
		end
		if (!done) begin
			$display("timeout: done was never raised in test %s", name);
			num_errors++;
			timed_out = 1'b1;
		end
		check_value({name, " busy low while running"}, 0, busy_low);
		check_value({name, " host not granted first"}, 0, host_lost);
		check_value({name, " busy at done"}, 1, int'(busy));
		@(negedge clk);
		check_value({name, " done width"}, 0, int'(done));
		check_value({name, " busy after done"}, 0, int'(busy));
		@(posedge clk);
		#5;
		host_req = '0;
		// watch as long as a second run would take
		extra_done = 0;
		repeat (t + 10) begin
			@(negedge clk);
			if (done) begin
				extra_done++;
			end
		end
		check_value({name, " second done"}, 0, extra_done);
		@(posedge clk);
		#5;
	endtask

	initial begin
		int     n;
		int     half;
		int     nin;
		int     idx;
		int     errs_before;
		int     checks_before;
		pixel_t got;
		pixel_t m;
		rst        = 1'b0;
		start      = 1'b0;
		cfg        = '0;
		host_req   = '0;
		num_checks = 0;
		num_errors = 0;
		tests_run  = 0;
		timed_out  = 1'b0;

		// name, num_row, num_channel, in_base, out_base, fill, run
		names[0] = "host_rw";
		rows[0]  = '{cfg: '{6'd4, 3'd1, 10'd0, 10'd100}, fill: FILL_RANDOM, run: 1'b0};
		names[1] = "ramp_4x4";
		rows[1]  = '{cfg: '{6'd4, 3'd1, 10'd0, 10'd64}, fill: FILL_RAMP, run: 1'b1};
		names[2] = "random_8x8x2";
		rows[2]  = '{cfg: '{6'd8, 3'd2, 10'd128, 10'd300}, fill: FILL_RANDOM, run: 1'b1};
		names[3] = "negative_6x6x3";
		rows[3]  = '{cfg: '{6'd6, 3'd3, 10'd400, 10'd600}, fill: FILL_NEG, run: 1'b1};

		repeat (3) @(posedge clk);
		#5;
		rst = 1'b1;
		@(posedge clk);
		#5;

		for (int k = 0; k < NUM_TESTS && !timed_out; k++) begin
			errs_before   = num_errors;
			checks_before = num_checks;
			n    = int'(rows[k].cfg.num_row);
			half = n / 2;
			nin  = n * n * int'(rows[k].cfg.num_channel);
			for (int i = 0; i < nin; i++) begin
				case (rows[k].fill)
					FILL_RANDOM: img[i] = pixel_t'($random(seed));
					FILL_NEG:    img[i] = pixel_t'(-1 - (i % 128));
					default:     img[i] = pixel_t'((i % 64) + 1);
				endcase
			end
			for (int i = 0; i < nin && !timed_out; i++) begin
				host_access(names[k], 1'b1, rows[k].cfg.in_base + addr_t'(i), img[i], got);
			end
			if (rows[k].run && !timed_out) begin
				run_layer(names[k], rows[k].cfg);
			end
			// input region is rectified in place by a run
			for (int i = 0; i < nin && !timed_out; i++) begin
				host_access(names[k], 1'b0, rows[k].cfg.in_base + addr_t'(i), '0, got);
				check_value($sformatf("%s in[%0d]", names[k], i),
					rows[k].run ? int'(relu(img[i])) : int'(img[i]), int'(got));
			end
			if (rows[k].run) begin
				for (int c = 0; c < int'(rows[k].cfg.num_channel) && !timed_out; c++) begin
					for (int r = 0; r < half; r++) begin
						for (int col = 0; col < half; col++) begin
							m = pixel_t'(-128);
							for (int dy = 0; dy < 2; dy++) begin
								for (int dx = 0; dx < 2; dx++) begin
									idx = c * n * n + (2 * r + dy) * n + 2 * col + dx;
									if (relu(img[idx]) > m) begin
										m = relu(img[idx]);
									end
								end
							end
							idx = c * half * half + r * half + col;
							host_access(names[k], 1'b0,
								rows[k].cfg.out_base + addr_t'(idx), '0, got);
							check_value($sformatf("%s out[%0d]", names[k], idx),
								int'(m), int'(got));
						end
					end
				end
			end
			tests_run++;
			$display("test %s: %0d checks, %0d failures", names[k],
				num_checks - checks_before, num_errors - errs_before);
		end

		$display("tests %0d, checks %0d, failures %0d", tests_run, num_checks, num_errors);
		if (num_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
src/pool_pkg.sv
src/feature_ram.sv
src/mem_arbiter.sv
src/relu_unit.sv
src/pool_unit.sv
src/layer_sequencer.sv
src/pool_accel_top.sv
tb/pool_accel_properties.sv
tb/pool_accel_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module pool_accel_tb -f filelist.f

status=0
./obj_dir/Vpool_accel_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Checks failed" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
